/* Makefile */
# Verilator flow for the RV64I core testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/core_consts.svh */
// opcode, funct3 and reset constants shared by the core blocks and the testbench
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// major opcodes, instr[6:2]
`define OPCODE_LUI        5'b01101
`define OPCODE_AUIPC      5'b00101
`define OPCODE_OP_IMM     5'b00100
`define OPCODE_OP         5'b01100
`define OPCODE_OP_IMM32   5'b00110
`define OPCODE_JAL        5'b11011
`define OPCODE_JALR       5'b11001
`define OPCODE_BRANCH     5'b11000

// integer ALU funct3
`define FUNCT3_ADD_SUB    3'b000
`define FUNCT3_SLL        3'b001
`define FUNCT3_SLT        3'b010
`define FUNCT3_SLTU       3'b011
`define FUNCT3_XOR        3'b100
`define FUNCT3_SRL_SRA    3'b101
`define FUNCT3_OR         3'b110
`define FUNCT3_AND        3'b111

// branch funct3
`define FUNCT3_BEQ        3'b000
`define FUNCT3_BNE        3'b001
`define FUNCT3_BLT        3'b100
`define FUNCT3_BGE        3'b101
`define FUNCT3_BLTU       3'b110
`define FUNCT3_BGEU       3'b111

`define RESET_PC          64'h0000_0000_0000_0000
`define NUM_REGS          32

`endif

/* project.f */
+incdir+include
verilog/core_pkg.sv
verilog/phase_ctrl.sv
verilog/ifetch_apb.sv
verilog/regfile.sv
verilog/id_stage.sv
verilog/exe_stage.sv
verilog/rv_core_top.sv
testbench/tb_clk_gen.sv
testbench/tb_apb_imem.sv
testbench/tb_rv_core.sv

/* testbench/tb_apb_imem.sv */
// APB completer model of the instruction memory, holds the test program and adds wait states
`timescale 1ns/1ns

`include "core_consts.svh"

module tb_apb_imem import core_pkg::*; #(
  parameter int WORDS = 64
) (
  input  logic  clk,
  input  logic  rst_n_i,
  input  logic  psel_i,
  input  logic  penable_i,
  input  addr_t paddr_i,
  output inst_t prdata_o,
  output logic  pready_o
);

  localparam int AW = $clog2(WORDS);

  inst_t mem [WORDS];
  int    seed = 32'hf4aa;
  int    wait_cnt = 0;

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input int rd, input int rs1, input int rs2);
    return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPCODE_OP, 2'b11};
  endfunction

  function automatic inst_t enc_i(input logic [4:0] opc, input logic [2:0] f3,
                                  input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3, rd[4:0], opc, 2'b11};
  endfunction

  function automatic inst_t enc_u(input logic [4:0] opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc, 2'b11};
  endfunction

  function automatic inst_t enc_j(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPCODE_JAL, 2'b11};
  endfunction

  function automatic inst_t enc_b(input logic [2:0] f3, input int rs1, input int rs2,
                                  input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
            `OPCODE_BRANCH, 2'b11};
  endfunction

  initial begin
    prdata_o = '0;
    pready_o = 1'b0;
    // unused words are nops tagged with their own index
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = enc_i(`OPCODE_OP_IMM, `FUNCT3_ADD_SUB, 0, 0, i);
    end
    mem[0]  = enc_u(`OPCODE_LUI, 1, 'h80000);
    mem[1]  = enc_i(`OPCODE_OP_IMM, `FUNCT3_ADD_SUB, 2, 0, -5);
    mem[2]  = enc_i(`OPCODE_OP_IMM, `FUNCT3_ADD_SUB, 3, 0, 3);
    mem[3]  = enc_u(`OPCODE_AUIPC, 4, 1);
    mem[4]  = enc_r(7'h20, `FUNCT3_ADD_SUB, 5, 3, 2);
    mem[5]  = enc_r(7'h00, `FUNCT3_SLT, 6, 2, 3);
    mem[6]  = enc_r(7'h00, `FUNCT3_SLTU, 7, 2, 3);
    mem[7]  = enc_r(7'h20, `FUNCT3_SRL_SRA, 8, 1, 3);
    // srai by 1, then 6-bit shift amounts
    mem[8]  = enc_i(`OPCODE_OP_IMM, `FUNCT3_SRL_SRA, 9, 2, 'h401);
    mem[9]  = enc_i(`OPCODE_OP_IMM, `FUNCT3_SLL, 10, 3, 40);
    mem[10] = enc_i(`OPCODE_OP_IMM, `FUNCT3_SRL_SRA, 11, 1, 33);
    // addiw wraps past bit 31 both ways
    mem[11] = enc_i(`OPCODE_OP_IMM32, `FUNCT3_ADD_SUB, 12, 1, -1);
    mem[12] = enc_i(`OPCODE_OP_IMM32, `FUNCT3_ADD_SUB, 13, 12, 1);
    mem[13] = enc_i(`OPCODE_OP_IMM, `FUNCT3_XOR, 14, 2, 'h7ff);
    mem[14] = enc_r(7'h00, `FUNCT3_OR, 15, 2, 3);
    mem[15] = enc_r(7'h00, `FUNCT3_AND, 16, 2, 3);
    mem[16] = enc_i(`OPCODE_OP_IMM, `FUNCT3_ADD_SUB, 0, 3, 7);
    mem[17] = enc_r(7'h00, `FUNCT3_ADD_SUB, 17, 0, 3);
    mem[18] = enc_i(`OPCODE_OP_IMM, `FUNCT3_SLT, 18, 2, -4);
    mem[19] = enc_i(`OPCODE_OP_IMM, `FUNCT3_SLTU, 19, 3, -1);
    mem[20] = enc_r(7'h00, `FUNCT3_SLL, 20, 3, 5);
    mem[21] = enc_r(7'h00, `FUNCT3_XOR, 24, 1, 2);
    mem[22] = enc_r(7'h00, `FUNCT3_SRL_SRA, 25, 2, 3);
    mem[23] = enc_j(26, 8);
    mem[25] = enc_u(`OPCODE_AUIPC, 27, 0);
    // odd target, bit 0 must be dropped
    mem[26] = enc_i(`OPCODE_JALR, 3'b000, 28, 27, 13);
    mem[28] = enc_b(`FUNCT3_BEQ, 3, 3, 8);
    mem[30] = enc_b(`FUNCT3_BNE, 3, 3, 8);
    mem[31] = enc_b(`FUNCT3_BLT, 2, 3, 8);
    mem[33] = enc_b(`FUNCT3_BGE, 2, 3, 8);
    mem[34] = enc_b(`FUNCT3_BLTU, 2, 3, 8);
    mem[35] = enc_b(`FUNCT3_BGEU, 2, 3, 8);
    mem[37] = enc_b(`FUNCT3_BGE, 3, 2, 8);
    mem[39] = enc_b(`FUNCT3_BLTU, 3, 2, 8);
    mem[41] = enc_b(`FUNCT3_BLT, 3, 2, 8);
    mem[42] = enc_b(`FUNCT3_BGEU, 3, 2, 8);
    mem[43] = enc_b(`FUNCT3_BEQ, 2, 3, 8);
    mem[44] = enc_b(`FUNCT3_BNE, 2, 3, 8);
    mem[46] = enc_b(`FUNCT3_BGE, 2, 2, 8);
    // parks the core in a self loop
    mem[48] = enc_j(0, 0);
  end

  // 0 to 3 wait states picked at each setup phase
  always @(negedge clk) begin
    if (!rst_n_i) begin
      pready_o <= 1'b0;
    end else if (psel_i && !penable_i) begin
      wait_cnt = $random(seed) & 3;
      pready_o <= 1'b0;
    end else if (psel_i && penable_i && !pready_o) begin
      if (wait_cnt == 0) begin
        pready_o <= 1'b1;
        prdata_o <= mem[paddr_i[AW+1:2]];
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end else begin
      pready_o <= 1'b0;
    end
  end

endmodule

/* testbench/tb_clk_gen.sv */
// clock and active-low reset source instantiated by the testbench top
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD     = 10,
  parameter int RST_CYCLES = 2
) (
  output logic clk,
  output logic rst_n_o
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // release lands after the falling-edge logic has seen reset
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n_o <= 1'b1;
  end

endmodule

/* testbench/tb_rv_core.sv */
// testbench top, runs the program through the core and checks each retire against a model
`timescale 1ns/1ns

`include "core_consts.svh"

module tb_rv_core import core_pkg::*; ();

  localparam int IMEM_WORDS = 64;
  localparam int IDX_MSB    = $clog2(IMEM_WORDS) + 1;
  localparam int PROG_LEN   = 49;
  localparam int MAX_CYCLES = PROG_LEN * 10 + 100;

  logic    clk;
  logic    rst_n;
  logic    psel;
  logic    penable;
  addr_t   paddr;
  inst_t   prdata;
  logic    pready;
  logic    retire_valid;
  retire_s retire;

  xlen_t mregs [`NUM_REGS];
  addr_t exp_pc     = `RESET_PC;
  int    cycles     = 0;
  int    retired    = 0;
  int    err_cnt    = 0;
  int    hs_age     = 100;
  logic  done       = 1'b0;
  logic  seen_fetch = 1'b0;
  logic  was_setup  = 1'b0;
  logic  in_wait    = 1'b0;
  addr_t wait_addr  = '0;

  tb_clk_gen #(.PERIOD(10), .RST_CYCLES(2)) u_clk_gen (
    .clk     (clk),
    .rst_n_o (rst_n)
  );

  tb_apb_imem #(.WORDS(IMEM_WORDS)) u_imem (
    .clk       (clk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .paddr_i   (paddr),
    .prdata_o  (prdata),
    .pready_o  (pready)
  );

  rv_core_top u_rv_core_top (
    .clk            (clk),
    .rst_n_i        (rst_n),
    .psel_o         (psel),
    .penable_o      (penable),
    .paddr_o        (paddr),
    .prdata_i       (prdata),
    .pready_i       (pready),
    .retire_valid_o (retire_valid),
    .retire_o       (retire)
  );

  task automatic fail_and_stop();
    $display("Checks failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    err_cnt++;
    fail_and_stop();
  endtask

  task automatic general_error(input string msg);
    $display("Error: %s", msg);
    err_cnt++;
    fail_and_stop();
  endtask

  function automatic xlen_t sign_extend(input xlen_t v, input int bits);
    xlen_t s;
    s = v << (64 - bits);
    return xlen_t'($signed(s) >>> (64 - bits));
  endfunction

  function automatic xlen_t shift_right_arith(input xlen_t v, input logic [5:0] sh);
    xlen_t fill;
    fill = v[63] ? ~(~64'd0 >> sh) : 64'd0;
    return (v >> sh) | fill;
  endfunction

  // architectural result of one instruction from the model registers
  task automatic predict_retire(input inst_t w, input addr_t pc, output logic wen,
                                output xlen_t data, output addr_t nxt);
    xlen_t       a;
    xlen_t       b;
    logic [5:0]  sh;
    logic [31:0] lo;
    logic        take;
    a    = mregs[w[19:15]];
    b    = mregs[w[24:20]];
    wen  = 1'b0;
    data = '0;
    nxt  = pc + 64'd4;
    take = 1'b0;
    case (w[6:2])
      `OPCODE_LUI: begin
        wen  = 1'b1;
        data = sign_extend(64'({w[31:12], 12'h000}), 32);
      end
      `OPCODE_AUIPC: begin
        wen  = 1'b1;
        data = pc + sign_extend(64'({w[31:12], 12'h000}), 32);
      end
      `OPCODE_OP_IMM, `OPCODE_OP: begin
        if (w[6:2] == `OPCODE_OP_IMM) b = sign_extend(64'(w[31:20]), 12);
        sh  = b[5:0];
        wen = 1'b1;
        case (w[14:12])
          // w[5] tells OP from OP-IMM, only OP subtracts
          `FUNCT3_ADD_SUB: data = (w[5] && w[30]) ? a - b : a + b;
          `FUNCT3_SLL:     data = a << sh;
          `FUNCT3_SLT:     data = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
          `FUNCT3_SLTU:    data = (a < b) ? 64'd1 : 64'd0;
          `FUNCT3_XOR:     data = a ^ b;
          `FUNCT3_SRL_SRA: data = w[30] ? shift_right_arith(a, sh) : a >> sh;
          `FUNCT3_OR:      data = a | b;
          default:         data = a & b;
        endcase
      end
      `OPCODE_OP_IMM32: begin
        if (w[14:12] == `FUNCT3_ADD_SUB) begin
          lo   = a[31:0] + {{20{w[31]}}, w[31:20]};
          wen  = 1'b1;
          data = sign_extend(64'(lo), 32);
        end
      end
      `OPCODE_JAL: begin
        wen  = 1'b1;
        data = pc + 64'd4;
        nxt  = pc + sign_extend(64'({w[31], w[19:12], w[20], w[30:21], 1'b0}), 21);
      end
      `OPCODE_JALR: begin
        wen    = 1'b1;
        data   = pc + 64'd4;
        nxt    = a + sign_extend(64'(w[31:20]), 12);
        nxt[0] = 1'b0;
      end
      `OPCODE_BRANCH: begin
        case (w[14:12])
          `FUNCT3_BEQ:  take = (a == b);
          `FUNCT3_BNE:  take = (a != b);
          `FUNCT3_BLT:  take = ($signed(a) < $signed(b));
          `FUNCT3_BGE:  take = !($signed(a) < $signed(b));
          `FUNCT3_BLTU: take = (a < b);
          `FUNCT3_BGEU: take = !(a < b);
          default:      take = 1'b0;
        endcase
        if (take) begin
          nxt = pc + sign_extend(64'({w[31], w[7], w[30:25], w[11:8], 1'b0}), 13);
        end
      end
      default: ;
    endcase
  endtask

  initial begin
    for (int i = 0; i < `NUM_REGS; i++) begin
      mregs[i] = '0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      general_error($sformatf("timeout, program did not finish in %0d cycles", MAX_CYCLES));
    end
  end

  // bus protocol and fetch to retire latency
  always @(posedge clk) begin
    assert (!penable || psel) else general_error("penable_o high without psel_o");
    if (!rst_n) begin
      assert (!retire_valid && !penable) else general_error("core active during reset");
    end else begin
      if (!seen_fetch && psel && !penable) begin
        assert (paddr == `RESET_PC)
          else mismatch($sformatf("first fetch address %h, expected %h", paddr, `RESET_PC));
        seen_fetch = 1'b1;
      end
      if (was_setup) begin
        assert (psel && penable) else general_error("setup phase not followed by access");
      end
      if (in_wait) begin
        assert (psel && penable) else general_error("access phase dropped during wait state");
        assert (paddr == wait_addr)
          else mismatch($sformatf("paddr_o moved to %h during wait, was %h", paddr, wait_addr));
      end
      was_setup = psel && !penable;
      in_wait   = psel && penable && !pready;
      wait_addr = paddr;
      if (psel && penable && pready) begin
        hs_age = 0;
      end else if (hs_age < 100) begin
        hs_age++;
      end
      assert (retire_valid == (hs_age == 3))
        else mismatch($sformatf("retire_valid_o is %b, %0d cycles after handshake",
                                retire_valid, hs_age));
    end
  end

  // reference model, one step per retire
  always @(posedge clk) begin
    inst_t w;
    logic  e_wen;
    xlen_t e_data;
    addr_t e_next;
    if (rst_n && retire_valid && !done) begin
      w = u_imem.mem[exp_pc[IDX_MSB:2]];
      assert (retire.pc == exp_pc)
        else mismatch($sformatf("retired pc %h, expected %h", retire.pc, exp_pc));
      assert (retire.inst == w)
        else mismatch($sformatf("retired inst %h, expected %h", retire.inst, w));
      assert (retire.rd == w[11:7])
        else mismatch($sformatf("retired rd %0d, expected %0d", retire.rd, w[11:7]));
      predict_retire(w, exp_pc, e_wen, e_data, e_next);
      assert (retire.rd_wen == e_wen)
        else mismatch($sformatf("rd_wen %b, expected %b at pc %h", retire.rd_wen, e_wen,
                                exp_pc));
      if (e_wen) begin
        assert (retire.rd_data == e_data)
          else mismatch($sformatf("rd_data %h, expected %h at pc %h", retire.rd_data,
                                  e_data, exp_pc));
        if (w[11:7] != 5'd0) mregs[w[11:7]] = e_data;
      end
      retired++;
      // self loop marks the end of the program
      if (e_next == exp_pc) done = 1'b1;
      exp_pc = e_next;
    end
  end

  initial begin
    wait (done);
    @(negedge clk);
    $display("retired %0d instructions in %0d cycles", retired, cycles);
    if (err_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      fail_and_stop();
    end
  end

endmodule

/* verilog/core_pkg.sv */
// common types of the multi-cycle core, imported by the RTL blocks and the testbench
package core_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_idx_t;

  // one instruction walks through these in order
  typedef enum logic [2:0] {
    PH_FETCH_SETUP,
    PH_FETCH_ACCESS,
    PH_DECODE,
    PH_EXECUTE,
    PH_WRITEBACK
  } phase_e;

  typedef struct packed {
    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_idx_t   rd;
    xlen_t      op1;
    xlen_t      op2;
    xlen_t      t1;
  } dec_s;

  typedef struct packed {
    logic  rd_wen;
    xlen_t rd_data;
    logic  pc_jmp;
    addr_t pc_jmpaddr;
  } exe_res_s;

  typedef struct packed {
    addr_t    pc;
    inst_t    inst;
    reg_idx_t rd;
    logic     rd_wen;
    xlen_t    rd_data;
  } retire_s;

endpackage

/* verilog/exe_stage.sv */
// execute stage, ALU result and write enable during execute, registered jump decision for the PC
`timescale 1ns/1ns

`include "core_consts.svh"

module exe_stage import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  phase_e   phase_i,
  input  dec_s     dec_i,
  output exe_res_s res_o
);

  logic        ex_active;
  logic        rd_wen;
  xlen_t       rd_data;
  logic        jmp_d;
  addr_t       jmpaddr_d;
  logic        pc_jmp_q;
  addr_t       pc_jmpaddr_q;
  logic [31:0] sum_w;

  assign ex_active = (phase_i == PH_EXECUTE);

  // shared by OP and OP-IMM, only OP can subtract
  function automatic xlen_t alu(input logic [2:0] funct3, input logic alt,
                                input logic sub_ok, input xlen_t a, input xlen_t b);
    logic [5:0] shamt;
    xlen_t      y;
    shamt = b[5:0];
    y     = '0;
    case (funct3)
      `FUNCT3_ADD_SUB: y = (sub_ok && alt) ? a - b : a + b;
      `FUNCT3_SLL:     y = a << shamt;
      `FUNCT3_SLT:     y = xlen_t'($signed(a) < $signed(b));
      `FUNCT3_SLTU:    y = xlen_t'(a < b);
      `FUNCT3_XOR:     y = a ^ b;
      `FUNCT3_SRL_SRA: y = alt ? xlen_t'($signed(a) >>> shamt) : a >> shamt;
      `FUNCT3_OR:      y = a | b;
      `FUNCT3_AND:     y = a & b;
      default:         y = '0;
    endcase
    return y;
  endfunction

  function automatic logic br_cond(input logic [2:0] funct3, input xlen_t a, input xlen_t b);
    case (funct3)
      `FUNCT3_BEQ:  return a == b;
      `FUNCT3_BNE:  return a != b;
      `FUNCT3_BLT:  return $signed(a) < $signed(b);
      `FUNCT3_BGE:  return $signed(a) >= $signed(b);
      `FUNCT3_BLTU: return a < b;
      `FUNCT3_BGEU: return a >= b;
      default:      return 1'b0;
    endcase
  endfunction

  assign sum_w = dec_i.op1[31:0] + dec_i.op2[31:0];

  // all zero outside execute
  always_comb begin
    rd_wen    = 1'b0;
    rd_data   = '0;
    jmp_d     = 1'b0;
    jmpaddr_d = '0;
    if (ex_active) begin
      case (dec_i.opcode)
        `OPCODE_LUI, `OPCODE_AUIPC: begin
          rd_wen  = 1'b1;
          rd_data = dec_i.op1 + dec_i.op2;
        end
        `OPCODE_OP_IMM: begin
          rd_wen  = 1'b1;
          rd_data = alu(dec_i.funct3, dec_i.funct7[5], 1'b0, dec_i.op1, dec_i.op2);
        end
        `OPCODE_OP: begin
          rd_wen  = 1'b1;
          rd_data = alu(dec_i.funct3, dec_i.funct7[5], 1'b1, dec_i.op1, dec_i.op2);
        end
        `OPCODE_OP_IMM32: begin
          // addiw only, other W forms retire without a write
          if (dec_i.funct3 == `FUNCT3_ADD_SUB) begin
            rd_wen  = 1'b1;
            rd_data = {{32{sum_w[31]}}, sum_w};
          end
        end
        `OPCODE_JAL: begin
          rd_wen    = 1'b1;
          rd_data   = dec_i.op1;
          jmp_d     = 1'b1;
          jmpaddr_d = dec_i.op2;
        end
        `OPCODE_JALR: begin
          rd_wen    = 1'b1;
          rd_data   = dec_i.t1;
          jmp_d     = 1'b1;
          jmpaddr_d = (dec_i.op1 + dec_i.op2) & ~addr_t'(1);
        end
        `OPCODE_BRANCH: begin
          jmp_d     = br_cond(dec_i.funct3, dec_i.op1, dec_i.op2);
          jmpaddr_d = dec_i.t1;
        end
        default: ;
      endcase
    end
  end

  // captured on the closing edge of execute, consumed in writeback
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_jmp_q     <= 1'b0;
      pc_jmpaddr_q <= '0;
    end else begin
      pc_jmp_q     <= jmp_d;
      pc_jmpaddr_q <= jmpaddr_d;
    end
  end

  assign res_o = '{rd_wen: rd_wen, rd_data: rd_data,
                   pc_jmp: pc_jmp_q, pc_jmpaddr: pc_jmpaddr_q};

endmodule

/* verilog/id_stage.sv */
// decoder, extracts fields from the latched instruction and picks op1, op2 and t1 for execute
`timescale 1ns/1ns

`include "core_consts.svh"

module id_stage import core_pkg::*; (
  input  inst_t    inst_i,
  input  addr_t    pc_i,
  output reg_idx_t rs1_o,
  output reg_idx_t rs2_o,
  input  xlen_t    rs1_data_i,
  input  xlen_t    rs2_data_i,
  output dec_s     dec_o
);

  logic [4:0] opcode;
  logic [2:0] funct3;
  xlen_t      imm_i;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm_b;
  addr_t      pc_plus4;
  logic       shift_imm;

  assign opcode = inst_i[6:2];
  assign funct3 = inst_i[14:12];
  assign rs1_o  = inst_i[19:15];
  assign rs2_o  = inst_i[24:20];

  // sign-extended immediates
  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                  inst_i[30:21], 1'b0};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                  inst_i[11:8], 1'b0};

  assign pc_plus4 = pc_i + addr_t'(4);

  // slli/srli/srai use instr[25] as shamt bit 5
  assign shift_imm = (opcode == `OPCODE_OP_IMM) &&
                     ((funct3 == `FUNCT3_SLL) || (funct3 == `FUNCT3_SRL_SRA));

  always_comb begin
    dec_o.opcode = opcode;
    dec_o.funct3 = funct3;
    dec_o.funct7 = shift_imm ? {inst_i[31:26], 1'b0} : inst_i[31:25];
    dec_o.rd     = inst_i[11:7];
    dec_o.op1    = '0;
    dec_o.op2    = '0;
    dec_o.t1     = '0;
    case (opcode)
      `OPCODE_AUIPC: begin
        dec_o.op1 = pc_i;
        dec_o.op2 = imm_u;
      end
      `OPCODE_LUI: begin
        dec_o.op2 = imm_u;
      end
      `OPCODE_OP_IMM, `OPCODE_OP_IMM32: begin
        dec_o.op1 = rs1_data_i;
        dec_o.op2 = imm_i;
      end
      `OPCODE_OP: begin
        dec_o.op1 = rs1_data_i;
        dec_o.op2 = rs2_data_i;
      end
      `OPCODE_JAL: begin
        dec_o.op1 = pc_plus4;
        dec_o.op2 = pc_i + imm_j;
      end
      `OPCODE_JALR: begin
        dec_o.op1 = rs1_data_i;
        dec_o.op2 = imm_i;
        dec_o.t1  = pc_plus4;
      end
      `OPCODE_BRANCH: begin
        dec_o.op1 = rs1_data_i;
        dec_o.op2 = rs2_data_i;
        dec_o.t1  = pc_i + imm_b;
      end
      default: ;
    endcase
  end

endmodule

/* verilog/ifetch_apb.sv */
// read-only APB requester, fetches the instruction word at the current PC for the decoder
`timescale 1ns/1ns

module ifetch_apb import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  phase_e phase_i,
  input  addr_t  pc_i,

  output logic   psel_o,
  output logic   penable_o,
  output addr_t  paddr_o,
  input  inst_t  prdata_i,
  input  logic   pready_i,

  output logic   fetch_done_o,
  output inst_t  inst_o
);

  logic  in_setup;
  logic  in_access;
  inst_t inst_q;

  assign in_setup  = (phase_i == PH_FETCH_SETUP);
  assign in_access = (phase_i == PH_FETCH_ACCESS);

  // bus follows the phase directly, access is held until pready
  assign psel_o    = in_setup | in_access;
  assign penable_o = in_access;
  assign paddr_o   = pc_i;

  assign fetch_done_o = in_access & pready_i;

  // instruction stays put until the next completed transfer
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      inst_q <= '0;
    end else if (fetch_done_o) begin
      inst_q <= prdata_i;
    end
  end

  assign inst_o = inst_q;

endmodule

/* verilog/phase_ctrl.sv */
// instruction-cycle FSM and PC register, steps each instruction through its five phases
`timescale 1ns/1ns

`include "core_consts.svh"

module phase_ctrl import core_pkg::*; (
  input  logic   clk,
  input  logic   rst_n_i,
  input  logic   fetch_done_i,
  input  logic   pc_jmp_i,
  input  addr_t  pc_jmpaddr_i,
  output phase_e phase_o,
  output addr_t  pc_o
);

  phase_e phase_q;
  phase_e phase_d;
  addr_t  pc_q;

  always_comb begin
    phase_d = phase_q;
    case (phase_q)
      PH_FETCH_SETUP:  phase_d = PH_FETCH_ACCESS;
      // wait states from the memory stretch this phase
      PH_FETCH_ACCESS: if (fetch_done_i) phase_d = PH_DECODE;
      PH_DECODE:       phase_d = PH_EXECUTE;
      PH_EXECUTE:      phase_d = PH_WRITEBACK;
      PH_WRITEBACK:    phase_d = PH_FETCH_SETUP;
      default:         phase_d = PH_FETCH_SETUP;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q <= PH_FETCH_SETUP;
      pc_q    <= `RESET_PC;
    end else begin
      phase_q <= phase_d;
      // jump result was registered at the end of execute
      if (phase_q == PH_WRITEBACK) begin
        pc_q <= pc_jmp_i ? pc_jmpaddr_i : pc_q + addr_t'(4);
      end
    end
  end

  assign phase_o = phase_q;
  assign pc_o    = pc_q;

endmodule

/* verilog/regfile.sv */
// integer register file, two asynchronous read ports and one write port, x0 reads zero
`timescale 1ns/1ns

`include "core_consts.svh"

module regfile import core_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  input  reg_idx_t rs1_i,
  input  reg_idx_t rs2_i,
  output xlen_t    rs1_data_o,
  output xlen_t    rs2_data_o,
  input  logic     we_i,
  input  reg_idx_t rd_i,
  input  xlen_t    rd_data_i
);

  xlen_t regs [`NUM_REGS];

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= rd_data_i;
    end
  end

  // x0 never written so it stays zero
  assign rs1_data_o = regs[rs1_i];
  assign rs2_data_o = regs[rs2_i];

endmodule

/* verilog/rv_core_top.sv */
// core top level, connects the phase FSM, fetch, decode, register file and execute to APB
`timescale 1ns/1ns

module rv_core_top import core_pkg::*; (
  input  logic    clk,
  input  logic    rst_n_i,
  output logic    psel_o,
  output logic    penable_o,
  output addr_t   paddr_o,
  input  inst_t   prdata_i,
  input  logic    pready_i,
  output logic    retire_valid_o,
  output retire_s retire_o
);

  phase_e   phase;
  addr_t    pc;
  inst_t    inst;
  logic     fetch_done;
  reg_idx_t rs1;
  reg_idx_t rs2;
  xlen_t    rs1_data;
  xlen_t    rs2_data;
  dec_s     dec;
  exe_res_s exe_res;
  logic     ret_wen_q;
  xlen_t    ret_data_q;

  phase_ctrl u_phase_ctrl (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .fetch_done_i (fetch_done),
    .pc_jmp_i     (exe_res.pc_jmp),
    .pc_jmpaddr_i (exe_res.pc_jmpaddr),
    .phase_o      (phase),
    .pc_o         (pc)
  );

  ifetch_apb u_ifetch_apb (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .phase_i      (phase),
    .pc_i         (pc),
    .psel_o       (psel_o),
    .penable_o    (penable_o),
    .paddr_o      (paddr_o),
    .prdata_i     (prdata_i),
    .pready_i     (pready_i),
    .fetch_done_o (fetch_done),
    .inst_o       (inst)
  );

  id_stage u_id_stage (
    .inst_i     (inst),
    .pc_i       (pc),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .dec_o      (dec)
  );

  regfile u_regfile (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .we_i       (exe_res.rd_wen),
    .rd_i       (dec.rd),
    .rd_data_i  (exe_res.rd_data)
  );

  exe_stage u_exe_stage (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .phase_i (phase),
    .dec_i   (dec),
    .res_o   (exe_res)
  );

  // the write result only lives in execute, hold it for the trace
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ret_wen_q  <= 1'b0;
      ret_data_q <= '0;
    end else if (phase == PH_EXECUTE) begin
      ret_wen_q  <= exe_res.rd_wen;
      ret_data_q <= exe_res.rd_data;
    end
  end

  assign retire_valid_o = (phase == PH_WRITEBACK);
  assign retire_o = '{pc: pc, inst: inst, rd: dec.rd,
                      rd_wen: ret_wen_q, rd_data: ret_data_q};

endmodule
